/* Bender.yml */
package:
  name: cache_slice

sources:
  - source/cache_slice_pkg.sv
  - source/mem_cmd_to_cache.sv
  - source/slice_cache.sv
  - source/cache_slice.sv
  - target: test
    files:
      - verif/tb_mem_model.sv
      - verif/tb_cache_slice.sv

/* list.f */
source/cache_slice_pkg.sv
source/mem_cmd_to_cache.sv
source/slice_cache.sv
source/cache_slice.sv
verif/tb_mem_model.sv
verif/tb_cache_slice.sv

/* source/cache_slice.sv */
`timescale 1ns/10ps

module cache_slice
  import cache_slice_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  input  msg_type_t mem_cmd_type_i,
  input  paddr_t    mem_cmd_addr_i,
  input  dword_t    mem_cmd_data_i,
  input  logic      mem_cmd_v_i,
  output logic      mem_cmd_ready_o,

  output msg_type_t mem_resp_type_o,
  output paddr_t    mem_resp_addr_o,
  output dword_t    mem_resp_data_o,
  output logic      mem_resp_v_o,
  input  logic      mem_resp_yumi_i,

  output msg_type_t mem_cmd_header_type_o,
  output msg_size_t mem_cmd_header_size_o,
  output paddr_t    mem_cmd_header_addr_o,
  output logic      mem_cmd_header_v_o,
  input  logic      mem_cmd_header_yumi_i,

  output dword_t    mem_cmd_data_o,
  output logic      mem_cmd_data_v_o,
  input  logic      mem_cmd_data_yumi_i,

  input  msg_type_t mem_resp_header_type_i,
  input  paddr_t    mem_resp_header_addr_i,
  input  logic      mem_resp_header_v_i,
  output logic      mem_resp_header_ready_o,

  input  dword_t    mem_resp_data_i,
  input  logic      mem_resp_data_v_i,
  output logic      mem_resp_data_ready_o
);

  cache_op_t cache_op;
  paddr_t    cache_addr;
  dword_t    cache_data;
  logic      cache_pkt_v, cache_pkt_ready;
  dword_t    cache_rdata;
  logic      cache_data_v, cache_data_yumi;
  logic      dma_write_not_read;
  paddr_t    dma_addr;
  logic      dma_pkt_v, dma_pkt_yumi;
  logic      unused_resp_hdr;

  mem_cmd_to_cache u_cmd_to_cache (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .mem_cmd_type_i    (mem_cmd_type_i),
    .mem_cmd_addr_i    (mem_cmd_addr_i),
    .mem_cmd_data_i    (mem_cmd_data_i),
    .mem_cmd_v_i       (mem_cmd_v_i),
    .mem_cmd_ready_o   (mem_cmd_ready_o),
    .mem_resp_type_o   (mem_resp_type_o),
    .mem_resp_addr_o   (mem_resp_addr_o),
    .mem_resp_data_o   (mem_resp_data_o),
    .mem_resp_v_o      (mem_resp_v_o),
    .mem_resp_yumi_i   (mem_resp_yumi_i),
    .cache_op_o        (cache_op),
    .cache_addr_o      (cache_addr),
    .cache_data_o      (cache_data),
    .cache_pkt_v_o     (cache_pkt_v),
    .cache_pkt_ready_i (cache_pkt_ready),
    .cache_rdata_i     (cache_rdata),
    .cache_data_v_i    (cache_data_v),
    .cache_data_yumi_o (cache_data_yumi)
  );

  slice_cache u_cache (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .cache_op_i           (cache_op),
    .cache_addr_i         (cache_addr),
    .cache_data_i         (cache_data),
    .cache_pkt_v_i        (cache_pkt_v),
    .cache_pkt_ready_o    (cache_pkt_ready),
    .cache_rdata_o        (cache_rdata),
    .cache_data_v_o       (cache_data_v),
    .cache_data_yumi_i    (cache_data_yumi),
    .dma_write_not_read_o (dma_write_not_read),
    .dma_addr_o           (dma_addr),
    .dma_pkt_v_o          (dma_pkt_v),
    .dma_pkt_yumi_i       (dma_pkt_yumi),
    .dma_wdata_o          (mem_cmd_data_o),
    .dma_wdata_v_o        (mem_cmd_data_v_o),
    .dma_wdata_yumi_i     (mem_cmd_data_yumi_i),
    .dma_rdata_i          (mem_resp_data_i),
    .dma_rdata_v_i        (mem_resp_data_v_i),
    .dma_rdata_ready_o    (mem_resp_data_ready_o)
  );

  // ######################################################################
  // dma request to memory command header
  // ######################################################################
  assign mem_cmd_header_type_o = dma_write_not_read ? MSG_WR : MSG_RD;
  assign mem_cmd_header_size_o = BLOCK_SIZE_CODE;  // always a whole block.
  assign mem_cmd_header_addr_o = dma_addr;
  assign mem_cmd_header_v_o    = dma_pkt_v;
  assign dma_pkt_yumi          = mem_cmd_header_yumi_i;

  // cache is already waiting for the beats whenever a response header shows up,
  // and the protocol has no unsolicited responses.
  assign mem_resp_header_ready_o = 1'b1;
  assign unused_resp_hdr = ^{mem_resp_header_type_i, mem_resp_header_addr_i, mem_resp_header_v_i};

endmodule

/* source/cache_slice_pkg.sv */
package cache_slice_pkg;

  // ######################################################################
  // geometry
  // ######################################################################
  localparam int PADDR_WIDTH = 32;
  localparam int DWORD_WIDTH = 64;
  localparam int BLOCK_WORDS = 4;
  localparam int SETS        = 16;

  localparam int BLOCK_WIDTH = BLOCK_WORDS * DWORD_WIDTH;
  localparam int BYTE_BITS   = $clog2(DWORD_WIDTH / 8);  // byte within dword.
  localparam int WORD_BITS   = $clog2(BLOCK_WORDS);      // dword within block.
  localparam int OFFSET_BITS = BYTE_BITS + WORD_BITS;
  localparam int INDEX_BITS  = $clog2(SETS);
  localparam int TAG_BITS    = PADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

  typedef logic [PADDR_WIDTH-1:0] paddr_t;
  typedef logic [DWORD_WIDTH-1:0] dword_t;
  typedef logic [1:0]             msg_type_t;
  typedef logic [2:0]             msg_size_t;
  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [INDEX_BITS-1:0]  index_t;
  typedef logic [WORD_BITS-1:0]   word_sel_t;
  typedef logic [0:0]             cache_op_t;

  // ######################################################################
  // message codes
  // ######################################################################
  localparam msg_type_t MSG_RD = 2'b00;
  localparam msg_type_t MSG_WR = 2'b01;

  localparam cache_op_t OP_LOAD  = 1'b0;
  localparam cache_op_t OP_STORE = 1'b1;

  // size code from block width, 8 bytes is the floor.
  localparam msg_size_t BLOCK_SIZE_CODE =
    (BLOCK_WIDTH == 1024) ? 3'b111 :
    (BLOCK_WIDTH == 512)  ? 3'b110 :
    (BLOCK_WIDTH == 256)  ? 3'b101 :
    (BLOCK_WIDTH == 128)  ? 3'b100 :
                            3'b011;

endpackage

/* source/mem_cmd_to_cache.sv */
`timescale 1ns/10ps

module mem_cmd_to_cache
  import cache_slice_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  input  msg_type_t mem_cmd_type_i,
  input  paddr_t    mem_cmd_addr_i,
  input  dword_t    mem_cmd_data_i,
  input  logic      mem_cmd_v_i,
  output logic      mem_cmd_ready_o,

  output msg_type_t mem_resp_type_o,
  output paddr_t    mem_resp_addr_o,
  output dword_t    mem_resp_data_o,
  output logic      mem_resp_v_o,
  input  logic      mem_resp_yumi_i,

  output cache_op_t cache_op_o,
  output paddr_t    cache_addr_o,
  output dword_t    cache_data_o,
  output logic      cache_pkt_v_o,
  input  logic      cache_pkt_ready_i,

  input  dword_t    cache_rdata_i,
  input  logic      cache_data_v_i,
  output logic      cache_data_yumi_o
);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_RESPOND} state_e;

  state_e    state_q, state_d;
  logic      pkt_sent_q, pkt_sent_d;  // packet taken by cache.
  msg_type_t cmd_type_q;
  paddr_t    cmd_addr_q;
  dword_t    cmd_data_q;
  dword_t    resp_data_q;

  assign mem_cmd_ready_o   = (state_q == S_IDLE);
  assign cache_pkt_v_o     = (state_q == S_ISSUE) && !pkt_sent_q;
  assign cache_data_yumi_o = (state_q == S_ISSUE) && pkt_sent_q && cache_data_v_i;

  assign cache_op_o   = (cmd_type_q == MSG_WR) ? OP_STORE : OP_LOAD;
  assign cache_addr_o = cmd_addr_q;
  assign cache_data_o = cmd_data_q;

  assign mem_resp_v_o    = (state_q == S_RESPOND);
  assign mem_resp_type_o = cmd_type_q;  // echo of the command.
  assign mem_resp_addr_o = cmd_addr_q;
  assign mem_resp_data_o = resp_data_q;

  always_comb begin
    state_d    = state_q;
    pkt_sent_d = pkt_sent_q;
    unique case (state_q)
      S_IDLE: begin
        if (mem_cmd_v_i) begin
          state_d    = S_ISSUE;
          pkt_sent_d = 1'b0;
        end
      end
      S_ISSUE: begin
        if (cache_pkt_v_o && cache_pkt_ready_i) pkt_sent_d = 1'b1;
        if (cache_data_yumi_o) state_d = S_RESPOND;
      end
      S_RESPOND: if (mem_resp_yumi_i) state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= S_IDLE;
      pkt_sent_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      pkt_sent_q <= pkt_sent_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_cmd_v_i && mem_cmd_ready_o) begin
      cmd_type_q <= mem_cmd_type_i;
      cmd_addr_q <= mem_cmd_addr_i;
      cmd_data_q <= mem_cmd_data_i;
    end
    if (cache_data_yumi_o) resp_data_q <= (cmd_type_q == MSG_RD) ? cache_rdata_i : '0;
  end

  // response held until taken.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mem_resp_v_o && !mem_resp_yumi_i) |=> (mem_resp_v_o && $stable(mem_resp_type_o)
      && $stable(mem_resp_addr_o) && $stable(mem_resp_data_o)));

endmodule

/* source/slice_cache.sv */
`timescale 1ns/10ps

module slice_cache
  import cache_slice_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  input  cache_op_t cache_op_i,
  input  paddr_t    cache_addr_i,
  input  dword_t    cache_data_i,
  input  logic      cache_pkt_v_i,
  output logic      cache_pkt_ready_o,

  output dword_t    cache_rdata_o,
  output logic      cache_data_v_o,
  input  logic      cache_data_yumi_i,

  output logic      dma_write_not_read_o,
  output paddr_t    dma_addr_o,
  output logic      dma_pkt_v_o,
  input  logic      dma_pkt_yumi_i,

  output dword_t    dma_wdata_o,
  output logic      dma_wdata_v_o,
  input  logic      dma_wdata_yumi_i,

  input  dword_t    dma_rdata_i,
  input  logic      dma_rdata_v_i,
  output logic      dma_rdata_ready_o
);

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_EVICT_HDR, S_EVICT_DATA, S_FILL_HDR, S_FILL_DATA, S_DONE
  } state_e;

  // ######################################################################
  // arrays and request
  // ######################################################################
  logic [SETS-1:0] valid_q;
  logic [SETS-1:0] dirty_q;
  tag_t            tag_mem  [SETS];
  dword_t          data_mem [SETS][BLOCK_WORDS];

  state_e    state_q, state_d;
  word_sel_t beat_q;
  cache_op_t req_op_q;
  paddr_t    req_addr_q;
  dword_t    req_data_q;

  tag_t      req_tag;
  index_t    idx;
  word_sel_t word;
  logic      hit, last_beat, data_fire, store_fire, fill_fire, evict_fire;

  assign req_tag = req_addr_q[PADDR_WIDTH-1 -: TAG_BITS];
  assign idx     = req_addr_q[OFFSET_BITS +: INDEX_BITS];
  assign word    = req_addr_q[BYTE_BITS +: WORD_BITS];
  assign hit     = valid_q[idx] && (tag_mem[idx] == req_tag);

  assign last_beat  = (beat_q == word_sel_t'(BLOCK_WORDS - 1));
  assign data_fire  = cache_data_v_o && cache_data_yumi_i;
  assign store_fire = data_fire && (req_op_q == OP_STORE);
  assign fill_fire  = dma_rdata_v_i && dma_rdata_ready_o;
  assign evict_fire = dma_wdata_v_o && dma_wdata_yumi_i;

  // ######################################################################
  // handshakes
  // ######################################################################
  assign cache_pkt_ready_o = (state_q == S_IDLE);
  assign cache_data_v_o    = ((state_q == S_LOOKUP) && hit) || (state_q == S_DONE);
  assign cache_rdata_o     = data_mem[idx][word];

  assign dma_pkt_v_o          = (state_q == S_EVICT_HDR) || (state_q == S_FILL_HDR);
  assign dma_write_not_read_o = (state_q == S_EVICT_HDR);
  assign dma_addr_o = (state_q == S_EVICT_HDR)
                    ? {tag_mem[idx], idx, {OFFSET_BITS{1'b0}}}  // victim block.
                    : {req_tag, idx, {OFFSET_BITS{1'b0}}};

  assign dma_wdata_v_o     = (state_q == S_EVICT_DATA);
  assign dma_wdata_o       = data_mem[idx][beat_q];
  assign dma_rdata_ready_o = (state_q == S_FILL_DATA);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      S_IDLE: if (cache_pkt_v_i) state_d = S_LOOKUP;
      S_LOOKUP: begin
        if (hit) begin
          if (cache_data_yumi_i) state_d = S_IDLE;
        end else if (valid_q[idx] && dirty_q[idx]) begin
          state_d = S_EVICT_HDR;
        end else begin
          state_d = S_FILL_HDR;
        end
      end
      S_EVICT_HDR:  if (dma_pkt_yumi_i) state_d = S_EVICT_DATA;
      S_EVICT_DATA: if (evict_fire && last_beat) state_d = S_FILL_HDR;
      S_FILL_HDR:   if (dma_pkt_yumi_i) state_d = S_FILL_DATA;
      S_FILL_DATA:  if (fill_fire && last_beat) state_d = S_DONE;
      S_DONE:       if (cache_data_yumi_i) state_d = S_IDLE;
      default:      state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      beat_q  <= '0;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state_q <= state_d;
      if (evict_fire || fill_fire) beat_q <= beat_q + 1'b1;  // wraps after last beat.
      if (fill_fire && last_beat) begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b0;
      end
      if (store_fire) dirty_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_pkt_v_i && cache_pkt_ready_o) begin
      req_op_q   <= cache_op_i;
      req_addr_q <= cache_addr_i;
      req_data_q <= cache_data_i;
    end
    if (fill_fire) data_mem[idx][beat_q] <= dma_rdata_i;
    if (fill_fire && last_beat) tag_mem[idx] <= req_tag;
    if (store_fire) data_mem[idx][word] <= req_data_q;
  end

  // beats of each block start at offset zero.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_pkt_v_o |-> (beat_q == '0));

  // memory only sends beats after a read header.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_rdata_v_i |-> (state_q == S_FILL_DATA));

endmodule

/* verif/tb_cache_slice.sv */
`timescale 1ns/10ps

module tb_cache_slice
  import cache_slice_pkg::*;
();

  localparam int        CMD_TIMEOUT  = 100;
  localparam int        RESP_TIMEOUT = 500;
  localparam int        RANDOM_OPS   = 200;
  localparam msg_size_t SIZE_32B     = 3'b101;  // 32-byte block.

  logic      clk, arst_n;
  msg_type_t cmd_type, resp_type, hdr_type, rhdr_type;
  paddr_t    cmd_addr, resp_addr, hdr_addr, rhdr_addr;
  dword_t    cmd_data, resp_data, wdata, rdata;
  msg_size_t hdr_size;
  logic      cmd_v, cmd_ready, resp_v, resp_yumi, hdr_v, hdr_yumi;
  logic      wdata_v, wdata_yumi, rhdr_v, rhdr_ready, rdata_v, rdata_ready;

  dword_t          shadow [paddr_t];  // golden memory.
  logic [SETS-1:0] sh_valid, sh_dirty;
  tag_t            sh_tag [SETS];
  int              errors = 0;
  int              timeouts = 0;
  int              hdr_seen = 0;
  int              beat_seen = 0;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  cache_slice i_dut (
    .clk_i (clk), .arst_n_i (arst_n),
    .mem_cmd_type_i (cmd_type), .mem_cmd_addr_i (cmd_addr), .mem_cmd_data_i (cmd_data),
    .mem_cmd_v_i (cmd_v), .mem_cmd_ready_o (cmd_ready),
    .mem_resp_type_o (resp_type), .mem_resp_addr_o (resp_addr), .mem_resp_data_o (resp_data),
    .mem_resp_v_o (resp_v), .mem_resp_yumi_i (resp_yumi),
    .mem_cmd_header_type_o (hdr_type), .mem_cmd_header_size_o (hdr_size),
    .mem_cmd_header_addr_o (hdr_addr), .mem_cmd_header_v_o (hdr_v),
    .mem_cmd_header_yumi_i (hdr_yumi),
    .mem_cmd_data_o (wdata), .mem_cmd_data_v_o (wdata_v), .mem_cmd_data_yumi_i (wdata_yumi),
    .mem_resp_header_type_i (rhdr_type), .mem_resp_header_addr_i (rhdr_addr),
    .mem_resp_header_v_i (rhdr_v), .mem_resp_header_ready_o (rhdr_ready),
    .mem_resp_data_i (rdata), .mem_resp_data_v_i (rdata_v), .mem_resp_data_ready_o (rdata_ready)
  );

  tb_mem_model i_mem (
    .clk_i (clk), .hdr_type_i (hdr_type), .hdr_size_i (hdr_size), .hdr_addr_i (hdr_addr),
    .hdr_v_i (hdr_v), .hdr_yumi_o (hdr_yumi), .wdata_i (wdata), .wdata_v_i (wdata_v),
    .wdata_yumi_o (wdata_yumi), .rdata_o (rdata), .rdata_v_o (rdata_v),
    .rdata_ready_i (rdata_ready)
  );

  // ####################################################################
  // helpers and compares
  // ####################################################################
  function automatic dword_t shadow_word(paddr_t addr);
    if (shadow.exists(addr)) return shadow[addr];
    return i_mem.fill_word(addr);
  endfunction

  function automatic paddr_t make_addr(tag_t tg, index_t set, word_sel_t w);
    return {tg, set, w, {BYTE_BITS{1'b0}}};
  endfunction

  task automatic check_dword(dword_t act, dword_t exp, string what);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_addr(paddr_t act, paddr_t exp, string what);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_type(msg_type_t act, msg_type_t exp, string what);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, act, exp);
    end
  endtask

  task automatic check_size(msg_size_t act, msg_size_t exp, string what);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, act, exp);
    end
  endtask

  // ####################################################################
  // command and response handshakes
  // ####################################################################
  task automatic send_cmd(msg_type_t typ, paddr_t addr, dword_t data);
    int n;
    n = 0;
    @(posedge clk);
    cmd_type <= typ;
    cmd_addr <= addr;
    cmd_data <= data;
    cmd_v    <= 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!cmd_ready && n < CMD_TIMEOUT);
    if (!cmd_ready) begin
      timeouts++;
      $display("Timeout: the DUT never accepted the command for %h", addr);
    end
    @(posedge clk);  // command transfers here.
    cmd_v <= 1'b0;
  endtask

  task automatic wait_resp(output int lat);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!resp_v && lat < RESP_TIMEOUT);
    if (!resp_v) begin
      timeouts++;
      $display("Timeout: no memory response came from the DUT");
    end
  endtask

  task automatic take_resp();
    @(posedge clk);
    resp_yumi <= 1'b1;
    @(posedge clk);
    resp_yumi <= 1'b0;
  endtask

  task automatic expect_header(msg_type_t typ, paddr_t addr);
    if (hdr_seen >= i_mem.hdr_addr_q.size()) begin
      errors++;
      $display("Error at %0t: missing header of type %0d for %h", $time, typ, addr);
    end else begin
      check_type(i_mem.hdr_type_q[hdr_seen], typ, "header type");
      check_size(i_mem.hdr_size_q[hdr_seen], SIZE_32B, "header size");
      check_addr(i_mem.hdr_addr_q[hdr_seen], addr, "header address");
      hdr_seen++;
    end
  endtask

  task automatic expect_evict_beats(paddr_t base);
    int k;
    for (k = 0; k < BLOCK_WORDS; k++) begin
      if (beat_seen >= i_mem.wbeat_q.size()) begin
        errors++;
        $display("Error at %0t: write beat %0d of block %h missing", $time, k, base);
      end else begin
        check_dword(i_mem.wbeat_q[beat_seen], shadow_word(paddr_t'(base + 8 * k)),
                    "evicted dword");
        beat_seen++;
      end
    end
  endtask

  // one command, full response check, then header traffic from the shadow tags.
  task automatic access(msg_type_t typ, paddr_t addr, dword_t data, int hold, output int lat);
    index_t set;
    tag_t   tg;
    paddr_t victim;
    dword_t exp_data;
    int     i;
    set      = addr[OFFSET_BITS +: INDEX_BITS];
    tg       = addr[PADDR_WIDTH-1 -: TAG_BITS];
    exp_data = (typ == MSG_WR) ? '0 : shadow_word(addr);
    lat      = 0;
    if (timeouts + i_mem.timeouts != 0) return;
    send_cmd(typ, addr, data);
    wait_resp(lat);
    if (timeouts != 0) return;
    for (i = 0; i <= hold; i++) begin
      if (i > 0) @(negedge clk);
      check_type(resp_type, typ, "response type");
      check_addr(resp_addr, addr, "response address");
      check_dword(resp_data, exp_data, "response data");
      if (!resp_v || cmd_ready) begin
        errors++;
        $display("Error at %0t: response dropped or command ready while held", $time);
      end
    end
    take_resp();
    if (!(sh_valid[set] && sh_tag[set] == tg)) begin
      if (sh_valid[set] && sh_dirty[set]) begin
        victim = make_addr(sh_tag[set], set, '0);
        expect_header(MSG_WR, victim);
        expect_evict_beats(victim);
      end
      expect_header(MSG_RD, make_addr(tg, set, '0));
      sh_valid[set] = 1'b1;
      sh_tag[set]   = tg;
      sh_dirty[set] = 1'b0;
    end
    if (typ == MSG_WR) begin
      sh_dirty[set] = 1'b1;
      shadow[addr]  = data;
    end
    if (i_mem.hdr_addr_q.size() != hdr_seen) begin
      errors++;
      $display("Error at %0t: unexpected header after access to %h", $time, addr);
      hdr_seen = i_mem.hdr_addr_q.size();
    end
  endtask

  // ####################################################################
  // directed tests
  // ####################################################################
  task automatic test_read_miss();
    int lat;
    access(MSG_RD, make_addr(tag_t'(5), index_t'(1), word_sel_t'(2)), '0, 0, lat);
  endtask

  task automatic test_write_read_hit();
    paddr_t a;
    int     lat;
    a = make_addr(tag_t'(7), index_t'(2), word_sel_t'(1));
    access(MSG_WR, a, 64'h1234_5678_9abc_def0, 0, lat);
    access(MSG_RD, a, '0, 0, lat);  // hit without a header.
  endtask

  task automatic test_dirty_eviction();
    int hdr_before;
    int lat;
    access(MSG_WR, make_addr(tag_t'(9), index_t'(3), word_sel_t'(2)), 64'hdead_beef_0bad_f00d,
           0, lat);
    hdr_before = hdr_seen;
    access(MSG_RD, make_addr(tag_t'(10), index_t'(3), word_sel_t'(0)), '0, 0, lat);
    if (hdr_seen - hdr_before != 2) begin
      errors++;
      $display("Error at %0t: dirty miss gave %0d headers", $time, hdr_seen - hdr_before);
    end
  endtask

  task automatic test_hit_latency();
    int lat;
    access(MSG_RD, make_addr(tag_t'(10), index_t'(3), word_sel_t'(1)), '0, 0, lat);
    if (lat != 3 && timeouts == 0) begin
      errors++;
      $display("Error at %0t: hit response after %0d cycles, expected 3", $time, lat);
    end
  endtask

  task automatic test_backpressure();
    int lat;
    access(MSG_RD, make_addr(tag_t'(10), index_t'(3), word_sel_t'(3)), '0, 6, lat);
  endtask

  task automatic test_random_mix();
    paddr_t    a;
    msg_type_t typ;
    int        k;
    int        lat;
    for (k = 0; k < RANDOM_OPS; k++) begin
      a   = make_addr(tag_t'(4 + $urandom % 3), index_t'($urandom % SETS),
                      word_sel_t'($urandom % BLOCK_WORDS));
      typ = ($urandom % 2) ? MSG_WR : MSG_RD;
      access(typ, a, {$urandom, $urandom}, 0, lat);
    end
  endtask

  initial begin
    int seed;
    seed      = $urandom(71020);
    arst_n    = 1'b0;
    cmd_type  = MSG_RD;
    cmd_addr  = '0;
    cmd_data  = '0;
    cmd_v     = 1'b0;
    resp_yumi = 1'b0;
    rhdr_type = MSG_RD;
    rhdr_addr = '0;
    rhdr_v    = 1'b0;
    sh_valid  = '0;
    sh_dirty  = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (resp_v || hdr_v || wdata_v || !cmd_ready || !rhdr_ready) begin
      errors++;
      $display("Error at %0t: outputs not idle after reset", $time);
    end
    test_read_miss();
    test_write_read_hit();
    test_dirty_eviction();
    test_hit_latency();
    test_backpressure();
    test_random_mix();
    $display("errors: %0d, timeouts: %0d", errors, timeouts + i_mem.timeouts);
    if (errors == 0 && timeouts + i_mem.timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verif/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model
  import cache_slice_pkg::*;
(
  input  logic      clk_i,
  input  msg_type_t hdr_type_i,
  input  msg_size_t hdr_size_i,
  input  paddr_t    hdr_addr_i,
  input  logic      hdr_v_i,
  output logic      hdr_yumi_o,
  input  dword_t    wdata_i,
  input  logic      wdata_v_i,
  output logic      wdata_yumi_o,
  output dword_t    rdata_o,
  output logic      rdata_v_o,
  input  logic      rdata_ready_i
);

  localparam int BEAT_TIMEOUT = 100;

  dword_t    backing [paddr_t];  // main memory contents.
  msg_type_t hdr_type_q [$];
  msg_size_t hdr_size_q [$];
  paddr_t    hdr_addr_q [$];
  dword_t    wbeat_q [$];        // write beats in arrival order.
  int        timeouts = 0;

  // unwritten memory, pattern from the whole address.
  function automatic dword_t fill_word(paddr_t addr);
    return {addr, ~addr};
  endfunction

  function automatic dword_t read_word(paddr_t addr);
    if (backing.exists(addr)) return backing[addr];
    return fill_word(addr);
  endfunction

  task automatic serve_header();
    msg_type_t typ;
    paddr_t    base;
    int        n;
    int        k;
    typ  = hdr_type_i;
    base = hdr_addr_i;
    hdr_type_q.push_back(typ);
    hdr_size_q.push_back(hdr_size_i);
    hdr_addr_q.push_back(base);
    @(posedge clk_i);
    hdr_yumi_o <= 1'b1;
    @(posedge clk_i);
    hdr_yumi_o <= 1'b0;
    for (k = 0; k < BLOCK_WORDS; k++) begin
      n = 0;
      if (typ == MSG_WR) begin
        do begin
          @(negedge clk_i);
          n++;
        end while (!wdata_v_i && n < BEAT_TIMEOUT);
        if (!wdata_v_i) begin
          timeouts++;
          $display("Timeout: write beat %0d never arrived from the DUT", k);
          return;
        end
        wbeat_q.push_back(wdata_i);
        backing[paddr_t'(base + 8 * k)] = wdata_i;
        @(posedge clk_i);
        wdata_yumi_o <= 1'b1;
        @(posedge clk_i);
        wdata_yumi_o <= 1'b0;
      end else begin
        rdata_v_o <= 1'b1;
        rdata_o   <= read_word(paddr_t'(base + 8 * k));
        do begin
          @(negedge clk_i);
          n++;
        end while (!rdata_ready_i && n < BEAT_TIMEOUT);
        if (!rdata_ready_i) begin
          timeouts++;
          $display("Timeout: the DUT never took fill beat %0d", k);
          rdata_v_o <= 1'b0;
          return;
        end
        @(posedge clk_i);  // beat taken here.
      end
    end
    rdata_v_o <= 1'b0;
  endtask

  initial begin
    hdr_yumi_o   = 1'b0;
    wdata_yumi_o = 1'b0;
    rdata_v_o    = 1'b0;
    rdata_o      = '0;
    forever begin
      @(negedge clk_i);
      if (hdr_v_i) serve_header();
    end
  end

endmodule
